// File: src/hyper_wpack_pkg.sv
/*
 * hyperbus write packing, bus-side types
 * beat, strobe and word formats seen at the path's ports
 */
`default_nettype none

package hyper_wpack_pkg;

  localparam int DataWidth = 32;
  localparam int StrbWidth = 4;
  localparam int LaneWidth = DataWidth / StrbWidth;  // bits per byte lane

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // byte lane within a word
  typedef logic [1:0] lane_idx_t;

  // width of the incoming beats
  typedef enum logic [1:0] {
    BwByte = 2'd0,
    BwHalf = 2'd1,
    BwWord = 2'd2
  } beat_width_e;

  // packed word as handed to the phy
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } word_t;

endpackage

`default_nettype wire

// File: src/hyper_wpack_ctrl_pkg.sv
/*
 * hyperbus write packing, control-side definitions
 * fsm states and lane counts
 */
`default_nettype none

package hyper_wpack_ctrl_pkg;

  localparam int LanesPerWord = 4;
  localparam int HalfLanes    = 2;  // step of a 16-bit beat

  // lane count and lane sum, wide enough for index + 4
  typedef logic [2:0] lane_cnt_t;

  typedef enum logic [1:0] {
    Idle      = 2'd0,
    Sample    = 2'd1,
    WaitReady = 2'd2
  } wpack_state_e;

endpackage

`default_nettype wire

// File: src/hyper_lane_if.sv
/*
 * lane position and progress shared by tracker, packer and fsm
 */
`default_nettype none

interface hyper_lane_if;

  hyper_wpack_pkg::lane_idx_t byte_idx;
  logic first_word;  // until first word of the burst is out
  logic word_done;   // current beat closes a word
  logic beat_fire;
  logic word_fire;
  logic txn_load;

  modport tracker (
    output byte_idx, first_word, word_done,
    input  beat_fire, word_fire, txn_load
  );

  modport packer (
    input byte_idx, word_done, beat_fire, word_fire
  );

  modport ctrl (
    input  word_done, first_word,
    output beat_fire, word_fire, txn_load
  );

endinterface

`default_nettype wire

// File: src/hyper_txn_cfg.sv
/*
 * transaction config, holds beat width and start offset for a burst
 */
`default_nettype none

module hyper_txn_cfg (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        txn_load_i,
  input  hyper_wpack_pkg::beat_width_e width_i,
  input  hyper_wpack_pkg::lane_idx_t   offset_i,
  output hyper_wpack_pkg::beat_width_e width_o,
  output hyper_wpack_pkg::lane_idx_t   offset_o
);

  hyper_wpack_pkg::beat_width_e width_q;
  hyper_wpack_pkg::lane_idx_t   offset_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      width_q  <= hyper_wpack_pkg::BwByte;
      offset_q <= '0;
    end else if (txn_load_i) begin
      width_q  <= width_i;
      offset_q <= offset_i;
    end
  end

  // pass through on the load cycle so the tracker takes the new offset
  assign width_o  = txn_load_i ? width_i : width_q;
  assign offset_o = txn_load_i ? offset_i : offset_q;

  half_offset_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    txn_load_i && (width_i == hyper_wpack_pkg::BwHalf) |-> !offset_i[0])
    else $error("halfword transaction loaded with odd offset %0d", offset_i);

  word_offset_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    txn_load_i && (width_i == hyper_wpack_pkg::BwWord) |-> offset_i == '0)
    else $error("word transaction loaded with offset %0d", offset_i);

endmodule

`default_nettype wire

// File: src/hyper_lane_tracker.sv
/*
 * byte lane tracker, follows the lane of each accepted beat
 * and flags the beat that closes a word
 */
`default_nettype none

module hyper_lane_tracker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  hyper_wpack_pkg::beat_width_e width_i,
  input  hyper_wpack_pkg::lane_idx_t   offset_i,
  input  logic                         last_i,
  hyper_lane_if.tracker                lane
);

  hyper_wpack_ctrl_pkg::lane_cnt_t lane_cnt;
  hyper_wpack_ctrl_pkg::lane_cnt_t lane_sum;
  hyper_wpack_pkg::lane_idx_t      byte_idx_q;
  logic                            first_word_q;

  // lanes covered by one beat
  always_comb begin
    unique case (width_i)
      hyper_wpack_pkg::BwHalf: begin
        lane_cnt = hyper_wpack_ctrl_pkg::lane_cnt_t'(hyper_wpack_ctrl_pkg::HalfLanes);
      end
      hyper_wpack_pkg::BwWord: begin
        lane_cnt = hyper_wpack_ctrl_pkg::lane_cnt_t'(hyper_wpack_ctrl_pkg::LanesPerWord);
      end
      default: lane_cnt = 3'd1;
    endcase
  end

  assign lane_sum = {1'b0, byte_idx_q} + lane_cnt;

  // top lane reaches lane 3 when the sum passes the word boundary
  assign lane.word_done  = (lane_sum >= hyper_wpack_ctrl_pkg::lane_cnt_t'(
                              hyper_wpack_ctrl_pkg::LanesPerWord)) | last_i;
  assign lane.byte_idx   = byte_idx_q;
  assign lane.first_word = first_word_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_idx_q   <= '0;
      first_word_q <= 1'b0;
    end else if (lane.txn_load) begin
      byte_idx_q   <= offset_i;
      first_word_q <= 1'b1;
    end else begin
      if (lane.beat_fire) begin
        byte_idx_q <= lane_sum[1:0];  // wraps mod 4
      end
      if (lane.word_fire) begin
        first_word_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/hyper_word_packer.sv
/*
 * word packer, merges the lanes of accepted beats into one word
 * with byte strobes and last flag
 */
`default_nettype none

module hyper_word_packer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  hyper_wpack_pkg::beat_width_e width_i,
  input  hyper_wpack_pkg::data_t       in_data_i,
  input  hyper_wpack_pkg::strb_t       in_strb_i,
  input  logic                         in_last_i,
  hyper_lane_if.packer                 lane,
  output hyper_wpack_pkg::word_t       out_word_o
);

  hyper_wpack_pkg::strb_t lane_mask;
  hyper_wpack_pkg::word_t word_d;
  hyper_wpack_pkg::word_t word_q;
  logic                   pend_q;  // a finished word waits for the phy

  // lanes written by the current beat
  always_comb begin
    unique case (width_i)
      hyper_wpack_pkg::BwHalf: lane_mask = 4'b0011 << lane.byte_idx;
      hyper_wpack_pkg::BwWord: lane_mask = 4'b1111;
      default:                 lane_mask = 4'b0001 << lane.byte_idx;
    endcase
  end

  always_comb begin
    word_d = word_q;
    if (lane.word_fire) begin
      word_d.strb = '0;  // data lanes keep old contents
      word_d.last = 1'b0;
    end else if (lane.beat_fire) begin
      for (int i = 0; i < hyper_wpack_pkg::StrbWidth; i++) begin
        if (lane_mask[i]) begin
          word_d.data[i*hyper_wpack_pkg::LaneWidth +: hyper_wpack_pkg::LaneWidth] =
            in_data_i[i*hyper_wpack_pkg::LaneWidth +: hyper_wpack_pkg::LaneWidth];
          word_d.strb[i] = in_strb_i[i];
        end
      end
      word_d.last = in_last_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q <= '0;
      pend_q <= 1'b0;
    end else begin
      word_q <= word_d;
      if (lane.word_fire) begin
        pend_q <= 1'b0;
      end else if (lane.beat_fire && lane.word_done) begin
        pend_q <= 1'b1;
      end
    end
  end

  assign out_word_o = word_q;

  // no beat may land while the fsm holds a word
  hold_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pend_q && !lane.word_fire |=> $stable(word_q))
    else $error("word buffer changed while waiting for out_ready");

endmodule

`default_nettype wire

// File: src/hyper_wpack_ctrl.sv
/*
 * write packing fsm, sequences start, beat sampling and word hand-off
 */
`default_nettype none

module hyper_wpack_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  hyper_wpack_pkg::beat_width_e width_i,
  input  logic                         txn_start_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         out_ready_i,
  output logic                         out_valid_o,
  input  logic                         held_last_i,  // last flag of the held word
  hyper_lane_if.ctrl                   lane
);

  hyper_wpack_ctrl_pkg::wpack_state_e state_d, state_q;

  assign in_ready_o  = (state_q == hyper_wpack_ctrl_pkg::Sample);
  assign out_valid_o = (state_q == hyper_wpack_ctrl_pkg::WaitReady);

  assign lane.beat_fire = in_valid_i & in_ready_o;
  assign lane.word_fire = out_valid_o & out_ready_i;
  assign lane.txn_load  = txn_start_i & (state_q == hyper_wpack_ctrl_pkg::Idle);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      hyper_wpack_ctrl_pkg::Idle: begin
        if (lane.txn_load) begin
          state_d = hyper_wpack_ctrl_pkg::Sample;
        end
      end
      hyper_wpack_ctrl_pkg::Sample: begin
        if (lane.beat_fire && lane.word_done) begin
          state_d = hyper_wpack_ctrl_pkg::WaitReady;
        end
      end
      hyper_wpack_ctrl_pkg::WaitReady: begin
        if (lane.word_fire) begin
          state_d = held_last_i ? hyper_wpack_ctrl_pkg::Idle
                                : hyper_wpack_ctrl_pkg::Sample;
        end
      end
      default: state_d = hyper_wpack_ctrl_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= hyper_wpack_ctrl_pkg::Idle;
    end else begin
      state_q <= state_d;
    end
  end

  ready_valid_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_ready_o && out_valid_o))
    else $error("in_ready_o and out_valid_o high together");

  // full-width beats go straight out, one word each
  word_passthru_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lane.beat_fire && (width_i == hyper_wpack_pkg::BwWord) |-> lane.word_done)
    else $error("word beat did not complete a word");

  idle_first_word_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == hyper_wpack_ctrl_pkg::Idle) |-> !lane.first_word)
    else $error("first word still pending in idle");

endmodule

`default_nettype wire

// File: src/hyper_wpack_top.sv
/*
 * hyperbus write packing path, narrow write beats to 32-bit phy words
 */
`default_nettype none

module hyper_wpack_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         txn_start_i,
  input  hyper_wpack_pkg::beat_width_e txn_width_i,
  input  hyper_wpack_pkg::lane_idx_t   txn_offset_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  hyper_wpack_pkg::data_t       in_data_i,
  input  hyper_wpack_pkg::strb_t       in_strb_i,
  input  logic                         in_last_i,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output hyper_wpack_pkg::data_t       out_data_o,
  output hyper_wpack_pkg::strb_t       out_strb_o,
  output logic                         out_last_o
);

  hyper_wpack_pkg::beat_width_e txn_width;
  hyper_wpack_pkg::lane_idx_t   txn_offset;
  hyper_wpack_pkg::word_t       out_word;

  hyper_lane_if lane_if ();

  hyper_txn_cfg i_txn_cfg (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .txn_load_i (lane_if.txn_load),
    .width_i    (txn_width_i),
    .offset_i   (txn_offset_i),
    .width_o    (txn_width),
    .offset_o   (txn_offset)
  );

  hyper_lane_tracker i_lane_tracker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .width_i  (txn_width),
    .offset_i (txn_offset),
    .last_i   (in_last_i),
    .lane     (lane_if.tracker)
  );

  hyper_word_packer i_word_packer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .width_i    (txn_width),
    .in_data_i  (in_data_i),
    .in_strb_i  (in_strb_i),
    .in_last_i  (in_last_i),
    .lane       (lane_if.packer),
    .out_word_o (out_word)
  );

  hyper_wpack_ctrl i_wpack_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .width_i     (txn_width),
    .txn_start_i (txn_start_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .held_last_i (out_word.last),
    .lane        (lane_if.ctrl)
  );

  assign out_data_o = out_word.data;
  assign out_strb_o = out_word.strb;
  assign out_last_o = out_word.last;

endmodule

`default_nettype wire

// File: tb/hyper_wpack_checker.sv
/*
 * scoreboard for the write packing path that models the packed words
 * from accepted beats and compares every output handshake
 */
`default_nettype none

module hyper_wpack_checker (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         txn_start_i,
  input  hyper_wpack_pkg::beat_width_e txn_width_i,
  input  hyper_wpack_pkg::lane_idx_t   txn_offset_i,
  input  logic                         in_valid_i,
  input  logic                         in_ready_i,
  input  hyper_wpack_pkg::data_t       in_data_i,
  input  hyper_wpack_pkg::strb_t       in_strb_i,
  input  logic                         in_last_i,
  input  logic                         out_valid_i,
  input  logic                         out_ready_i,
  input  hyper_wpack_pkg::word_t       out_word_i,
  output int                           error_cnt_o,
  output int                           word_cnt_o,
  output logic                         idle_o
);

  hyper_wpack_ctrl_pkg::wpack_state_e st;
  hyper_wpack_pkg::beat_width_e       width;
  hyper_wpack_pkg::word_t             acc;  // model of the word buffer
  hyper_wpack_pkg::word_t             held;
  hyper_wpack_pkg::word_t             exp_w;
  hyper_wpack_pkg::word_t             exp_q[$];
  logic                               held_valid;
  logic                               exp_ready;
  logic                               exp_valid;
  int                                 idx;
  int                                 step;
  int                                 lane;
  string                              test_name;

  task automatic mismatch(input string what, input logic [36:0] exp_val,
                          input logic [36:0] act_val);
    $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp_val, act_val);
    error_cnt_o++;
  endtask

  task automatic complain(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    error_cnt_o++;
  endtask

  initial begin
    error_cnt_o = 0;
    word_cnt_o  = 0;
    test_name   = "reset_state";
  end

  // falling edge sees settled inputs and outputs
  always @(negedge clk_i) begin
    if (rst_ni !== 1'b1) begin
      st         = hyper_wpack_ctrl_pkg::Idle;
      acc        = '0;
      held_valid = 1'b0;
      exp_q.delete();
    end else begin
      exp_ready = (st == hyper_wpack_ctrl_pkg::Sample);
      exp_valid = (st == hyper_wpack_ctrl_pkg::WaitReady);
      if (in_ready_i !== exp_ready) begin
        mismatch("in_ready_o", exp_ready, in_ready_i);
      end
      if (out_valid_i !== exp_valid) begin
        mismatch("out_valid_o", exp_valid, out_valid_i);
      end
      if (held_valid && !out_valid_i) begin
        complain("out_valid_o dropped before its handshake");
      end else if (held_valid && out_word_i !== held) begin
        mismatch("held word", held, out_word_i);
      end
      if (out_valid_i && out_ready_i) begin
        word_cnt_o++;
        if (exp_q.size() == 0) begin
          complain("word handed out with no word expected");
        end else begin
          exp_w = exp_q.pop_front();
          if (out_word_i !== exp_w) begin
            mismatch("output word", exp_w, out_word_i);
          end
        end
      end
      case (st)
        hyper_wpack_ctrl_pkg::Idle: begin
          if (txn_start_i) begin
            width = txn_width_i;
            idx   = txn_offset_i;
            st    = hyper_wpack_ctrl_pkg::Sample;
            case (txn_width_i)
              hyper_wpack_pkg::BwByte: test_name = "byte_pack";
              hyper_wpack_pkg::BwHalf: test_name = "half_pack";
              default:                 test_name = "word_pass";
            endcase
          end
        end
        hyper_wpack_ctrl_pkg::Sample: begin
          if (in_valid_i) begin
            case (width)
              hyper_wpack_pkg::BwHalf: step = hyper_wpack_ctrl_pkg::HalfLanes;
              hyper_wpack_pkg::BwWord: step = hyper_wpack_ctrl_pkg::LanesPerWord;
              default:                 step = 1;
            endcase
            for (int k = 0; k < step; k++) begin
              lane = (idx + k) % 4;
              acc.data[lane*8 +: 8] = in_data_i[lane*8 +: 8];
              acc.strb[lane]        = in_strb_i[lane];
            end
            acc.last = in_last_i;
            if (idx + step >= 4 || in_last_i) begin
              exp_q.push_back(acc);
              st = hyper_wpack_ctrl_pkg::WaitReady;
            end
            idx = (idx + step) % 4;
          end
        end
        default: begin
          if (out_ready_i) begin
            st = acc.last ? hyper_wpack_ctrl_pkg::Idle : hyper_wpack_ctrl_pkg::Sample;
            acc.strb = '0;  // data lanes stay as they were
            acc.last = 1'b0;
          end
        end
      endcase
      held_valid = out_valid_i && !out_ready_i;
      held       = out_word_i;
    end
    idle_o = (st == hyper_wpack_ctrl_pkg::Idle) && (exp_q.size() == 0);
  end

endmodule

`default_nettype wire

// File: tb/tb_hyper_wpack.sv
/*
 * testbench for the hyperbus write packing path
 * seeded random bursts of all widths under random output back-pressure
 */
`default_nettype none

module tb_hyper_wpack;

  localparam int WaitLimit = 200;  // cycles per wait loop

  logic                         clk_i;
  logic                         rst_ni;
  logic                         txn_start_i;
  hyper_wpack_pkg::beat_width_e txn_width_i;
  hyper_wpack_pkg::lane_idx_t   txn_offset_i;
  logic                         in_valid_i;
  logic                         in_ready_o;
  hyper_wpack_pkg::data_t       in_data_i;
  hyper_wpack_pkg::strb_t       in_strb_i;
  logic                         in_last_i;
  logic                         out_valid_o;
  logic                         out_ready_i;
  hyper_wpack_pkg::data_t       out_data_o;
  hyper_wpack_pkg::strb_t       out_strb_o;
  logic                         out_last_o;
  int                           error_cnt;
  int                           word_cnt;
  logic                         model_idle;
  int                           seed;
  int                           ready_seed;
  int                           timeouts;

  hyper_wpack_top i_hyper_wpack_top (.*);

  hyper_wpack_checker i_hyper_wpack_checker (
    .clk_i, .rst_ni, .txn_start_i, .txn_width_i, .txn_offset_i,
    .in_valid_i, .in_ready_i (in_ready_o), .in_data_i, .in_strb_i, .in_last_i,
    .out_valid_i (out_valid_o), .out_ready_i,
    .out_word_i  ({out_data_o, out_strb_o, out_last_o}),
    .error_cnt_o (error_cnt),
    .word_cnt_o  (word_cnt),
    .idle_o      (model_idle)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    #2;
    out_ready_i = (($random(ready_seed) & 3) != 0);  // stall about one cycle in four
  end

  function automatic int rand_below(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  function automatic hyper_wpack_pkg::data_t lane_bits(input hyper_wpack_pkg::strb_t mask);
    hyper_wpack_pkg::data_t bits;
    for (int i = 0; i < 4; i++) begin
      bits[i*8 +: 8] = {8{mask[i]}};
    end
    return bits;
  endfunction

  task automatic pick_cfg(output hyper_wpack_pkg::beat_width_e w,
                          output hyper_wpack_pkg::lane_idx_t off);
    w = hyper_wpack_pkg::beat_width_e'(rand_below(3));
    case (w)
      hyper_wpack_pkg::BwByte: off = hyper_wpack_pkg::lane_idx_t'(rand_below(4));
      hyper_wpack_pkg::BwHalf: off = hyper_wpack_pkg::lane_idx_t'(2 * rand_below(2));
      default:                 off = 2'd0;
    endcase
  endtask

  task automatic send_beat(input hyper_wpack_pkg::data_t d, input hyper_wpack_pkg::strb_t s,
                           input logic last);
    int   waited;
    logic taken;
    in_valid_i = 1'b1;
    in_data_i  = d;
    in_strb_i  = s;
    in_last_i  = last;
    waited     = 0;
    taken      = 1'b0;
    while (!taken && waited < WaitLimit) begin
      @(negedge clk_i);
      taken = in_ready_o;
      @(posedge clk_i);
      #2;
      waited++;
    end
    in_valid_i = 1'b0;
    if (!taken) begin
      $display("timeout: beat not accepted within %0d cycles", WaitLimit);
      timeouts++;
    end
  endtask

  task automatic wait_last_word();
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < WaitLimit) begin
      @(negedge clk_i);
      seen = out_valid_o && out_ready_i && out_last_o;
      @(posedge clk_i);
      #2;
      txn_start_i = 1'b0;  // stray start lasts one cycle
      waited++;
    end
    if (!seen) begin
      $display("timeout: last word not handed out within %0d cycles", WaitLimit);
      timeouts++;
    end
  endtask

  task automatic run_txn(input hyper_wpack_pkg::beat_width_e w,
                         input hyper_wpack_pkg::lane_idx_t off, input int len);
    hyper_wpack_pkg::beat_width_e stray_w;
    hyper_wpack_pkg::lane_idx_t   stray_off;
    hyper_wpack_pkg::strb_t       mask;
    int                           idx;
    if (timeouts != 0) begin
      return;
    end
    txn_start_i  = 1'b1;
    txn_width_i  = w;
    txn_offset_i = off;
    @(posedge clk_i);
    #2;
    idx = off;
    for (int b = 0; b < len && timeouts == 0; b++) begin
      // wandering config and a mid-burst start must leave the burst alone
      pick_cfg(stray_w, stray_off);
      txn_width_i  = stray_w;
      txn_offset_i = stray_off;
      txn_start_i  = (b == 1);
      case (w)
        hyper_wpack_pkg::BwByte: mask = 4'b0001 << idx;
        hyper_wpack_pkg::BwHalf: mask = 4'b0011 << idx;
        default:                 mask = 4'b1111;
      endcase
      send_beat($random(seed) & lane_bits(mask),
                hyper_wpack_pkg::strb_t'($random(seed)) & mask, b == len - 1);
      idx = (idx + $countones(mask)) % 4;
    end
    txn_start_i = 1'b1;  // also while the last word waits
    if (timeouts == 0) begin
      wait_last_word();
    end
    txn_start_i = 1'b0;
  endtask

  initial begin
    hyper_wpack_pkg::beat_width_e w;
    hyper_wpack_pkg::lane_idx_t   off;
    seed         = 73;
    ready_seed   = 73;
    timeouts     = 0;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    txn_start_i  = 1'b0;
    txn_width_i  = hyper_wpack_pkg::BwByte;
    txn_offset_i = 2'd0;
    in_valid_i   = 1'b0;
    in_data_i    = '0;
    in_strb_i    = '0;
    in_last_i    = 1'b0;
    out_ready_i  = 1'b0;
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #2;
    for (int o = 0; o < 4; o++) begin
      run_txn(hyper_wpack_pkg::BwByte, hyper_wpack_pkg::lane_idx_t'(o), 1 + rand_below(12));
    end
    // lengths chosen so the last halfword lands in lanes 0 and 1
    run_txn(hyper_wpack_pkg::BwHalf, 2'd0, 1 + 2 * rand_below(6));
    run_txn(hyper_wpack_pkg::BwHalf, 2'd2, 2 + 2 * rand_below(6));
    run_txn(hyper_wpack_pkg::BwWord, 2'd0, 1 + rand_below(12));
    for (int t = 0; t < 40; t++) begin
      pick_cfg(w, off);
      run_txn(w, off, 1 + rand_below(12));
    end
    repeat (3) @(posedge clk_i);
    if (!model_idle) begin
      $display("expected words still outstanding at end of run");
    end
    $display("errors %0d, timeouts %0d, words %0d", error_cnt, timeouts, word_cnt);
    if (error_cnt == 0 && timeouts == 0 && model_idle && word_cnt > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
src/hyper_wpack_pkg.sv
src/hyper_wpack_ctrl_pkg.sv
src/hyper_lane_if.sv
src/hyper_txn_cfg.sv
src/hyper_lane_tracker.sv
src/hyper_word_packer.sv
src/hyper_wpack_ctrl.sv
src/hyper_wpack_top.sv
tb/hyper_wpack_checker.sv
tb/tb_hyper_wpack.sv

// File: Bender.yml
package:
  name: hyper_wpack

sources:
  - src/hyper_wpack_pkg.sv
  - src/hyper_wpack_ctrl_pkg.sv
  - src/hyper_lane_if.sv
  - src/hyper_txn_cfg.sv
  - src/hyper_lane_tracker.sv
  - src/hyper_word_packer.sv
  - src/hyper_wpack_ctrl.sv
  - src/hyper_wpack_top.sv
  - target: test
    files:
      - tb/hyper_wpack_checker.sv
      - tb/tb_hyper_wpack.sv
